//--- hdl/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // Layer geometry
    localparam int unsigned IFM_SIZE    = 8;
    localparam int unsigned KERNEL_SIZE = 3;
    localparam int unsigned NUM_FILTERS = 2;
    localparam int unsigned OFM_SIZE    = IFM_SIZE - KERNEL_SIZE + 1;
    localparam int unsigned KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE;
    localparam int unsigned FIFO_SIZE   = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;
    localparam int unsigned MAC_LATENCY = 4;

    // Memory depths with the biases after all weights
    localparam int unsigned IFM_WORDS  = IFM_SIZE * IFM_SIZE;
    localparam int unsigned OFM_WORDS  = NUM_FILTERS * OFM_SIZE * OFM_SIZE;
    localparam int unsigned BIAS_BASE  = KERNEL_TAPS * NUM_FILTERS;
    localparam int unsigned COEF_WORDS = BIAS_BASE + NUM_FILTERS;

    localparam int unsigned IFM_ADDR_W  = $clog2(IFM_WORDS);
    localparam int unsigned OFM_ADDR_W  = $clog2(OFM_WORDS);
    localparam int unsigned COEF_ADDR_W = $clog2(COEF_WORDS);
    localparam int unsigned FILT_W      = $clog2(NUM_FILTERS);
    localparam int unsigned LOAD_CNT_W  = $clog2(KERNEL_TAPS + 1);  // Weights plus bias
    localparam int unsigned POS_W       = $clog2(IFM_SIZE);

    localparam int unsigned DATA_W = 8;
    localparam int unsigned ACC_W  = 20;

    typedef logic signed [DATA_W-1:0] pixel_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    typedef enum logic [1:0] {IDLE, LOAD_W, READ, DRAIN} ctrl_state_e;
    typedef enum logic {HAND_FREE, HAND_WAIT} handoff_state_e;

endpackage

`default_nettype wire

//--- hdl/ifm_ram.sv
`timescale 1ns/10ps
`default_nettype none

module ifm_ram
(
    input  logic                            clk,
    input  logic                            we,
    input  logic [conv_pkg::IFM_ADDR_W-1:0] wr_addr,
    input  conv_pkg::pixel_t                wr_data,
    input  logic                            rd_en,
    input  logic [conv_pkg::IFM_ADDR_W-1:0] rd_addr,
    output conv_pkg::pixel_t                rd_data
);

    conv_pkg::pixel_t mem [conv_pkg::IFM_WORDS];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[wr_addr] <= wr_data;
        if (rd_en)
            rd_data <= mem[rd_addr];    // One cycle read
    end

endmodule

`default_nettype wire

//--- hdl/line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module line_buffer
(
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic                                           shift_en,
    input  conv_pkg::pixel_t                               pixel_in,
    output conv_pkg::pixel_t [conv_pkg::KERNEL_TAPS-1:0]   window
);

    // Index 0 holds the newest pixel
    conv_pkg::pixel_t [conv_pkg::FIFO_SIZE-1:0] chain;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            chain <= '0;
        else if (shift_en)
            chain <= {chain[conv_pkg::FIFO_SIZE-2:0], pixel_in};
    end

    // Tap (i, j) lies (K-1-i) rows and (K-1-j) columns behind the newest pixel
    for (genvar i = 0; i < conv_pkg::KERNEL_SIZE; i++)
    begin : g_row
        for (genvar j = 0; j < conv_pkg::KERNEL_SIZE; j++)
        begin : g_col
            assign window[i*conv_pkg::KERNEL_SIZE + j] =
                chain[(conv_pkg::KERNEL_SIZE-1-i)*conv_pkg::IFM_SIZE + (conv_pkg::KERNEL_SIZE-1-j)];
        end
    end

endmodule

`default_nettype wire

//--- hdl/kernel_store.sv
`timescale 1ns/10ps
`default_nettype none

module kernel_store
(
    input  logic                                         clk,
    input  logic                                         we,
    input  logic [conv_pkg::COEF_ADDR_W-1:0]             wr_addr,
    input  conv_pkg::pixel_t                             wr_data,
    input  logic [conv_pkg::COEF_ADDR_W-1:0]             rd_addr,
    input  logic                                         w_shift_en,
    input  logic                                         bias_sel,
    output conv_pkg::pixel_t [conv_pkg::KERNEL_TAPS-1:0] weights,
    output conv_pkg::pixel_t                             bias
);

    conv_pkg::pixel_t mem [conv_pkg::COEF_WORDS];
    conv_pkg::pixel_t rd_word;

    ////////////////////////////////////////////////////////////
    // Coefficient RAM
    always_ff @(posedge clk)
    begin
        if (we)
            mem[wr_addr] <= wr_data;
        rd_word <= mem[rd_addr];
    end

    ////////////////////////////////////////////////////////////
    // Active kernel

    // Enters at the top, so the first word read ends up in tap 0
    always_ff @(posedge clk)
    begin
        if (w_shift_en)
            weights <= {rd_word, weights[conv_pkg::KERNEL_TAPS-1:1]};
    end

    always_ff @(posedge clk)
    begin
        if (bias_sel)
            bias <= rd_word;
    end

endmodule

`default_nettype wire

//--- hdl/conv_mac.sv
`timescale 1ns/10ps
`default_nettype none

module conv_mac
(
    input  logic                                         clk,
    input  logic                                         reset,
    input  conv_pkg::pixel_t [conv_pkg::KERNEL_TAPS-1:0] window,
    input  conv_pkg::pixel_t [conv_pkg::KERNEL_TAPS-1:0] weights,
    input  conv_pkg::pixel_t                             bias,
    output conv_pkg::acc_t                               result
);

    conv_pkg::acc_t prod [conv_pkg::KERNEL_TAPS];
    conv_pkg::acc_t part [conv_pkg::KERNEL_SIZE];
    conv_pkg::acc_t sum;

    ////////////////////////////////////////////////////////////
    // Products, then one row sum per kernel row, then the total
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int k = 0; k < conv_pkg::KERNEL_TAPS; k++)
                prod[k] <= '0;
            for (int g = 0; g < conv_pkg::KERNEL_SIZE; g++)
                part[g] <= '0;
            sum    <= '0;
            result <= '0;
        end
        else
        begin
            for (int k = 0; k < conv_pkg::KERNEL_TAPS; k++)
                prod[k] <= window[k] * weights[k];     // Signed, widened to acc_t
            for (int g = 0; g < conv_pkg::KERNEL_SIZE; g++)
                part[g] <= prod[3*g] + prod[3*g+1] + prod[3*g+2];
            sum    <= part[0] + part[1] + part[2];
            result <= sum + bias;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ofm_pingpong.sv
`timescale 1ns/10ps
`default_nettype none

module ofm_pingpong
(
    input  logic                            clk,
    input  logic                            we,
    input  logic [conv_pkg::OFM_ADDR_W-1:0] wr_addr,
    input  conv_pkg::acc_t                  wr_data,
    input  logic                            bank_sel,
    input  logic [conv_pkg::OFM_ADDR_W-1:0] rd_addr,
    output conv_pkg::acc_t                  rd_data
);

    conv_pkg::acc_t mem [2][conv_pkg::OFM_WORDS];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[bank_sel][wr_addr] <= wr_data;
    end

    // Reader always sees the bank not being written
    always_ff @(posedge clk)
    begin
        rd_data <= mem[~bank_sel][rd_addr];
    end

endmodule

`default_nettype wire

//--- hdl/conv_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module conv_ctrl
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start_from_previous,
    input  logic                             end_from_next,
    output logic                             ready,
    output logic                             start_to_next,
    output logic                             ifm_rd_en,
    output logic [conv_pkg::IFM_ADDR_W-1:0]  ifm_rd_addr,
    output logic [conv_pkg::COEF_ADDR_W-1:0] coef_rd_addr,
    output logic                             w_shift_en,
    output logic                             bias_sel,
    output logic                             shift_en,
    output logic                             win_valid,
    output logic                             ofm_we,
    output logic [conv_pkg::OFM_ADDR_W-1:0]  ofm_wr_addr,
    output logic                             bank_sel
);

    conv_pkg::ctrl_state_e            state;
    conv_pkg::handoff_state_e         hand_state;
    logic [conv_pkg::FILT_W-1:0]      filt_cnt;
    logic [conv_pkg::LOAD_CNT_W-1:0]  load_cnt;
    logic [conv_pkg::IFM_ADDR_W-1:0]  pix_cnt;
    logic [conv_pkg::POS_W-1:0]       row_cnt;
    logic [conv_pkg::POS_W-1:0]       col_cnt;
    logic [conv_pkg::MAC_LATENCY-1:0] we_pipe;
    logic                             load_done;
    logic                             read_done;
    logic                             drain_done;
    logic                             last_write;

    assign load_done  = (load_cnt == conv_pkg::KERNEL_TAPS);      // Bias read issued
    assign read_done  = (pix_cnt == conv_pkg::IFM_WORDS - 1);
    assign drain_done = !shift_en && !win_valid && (we_pipe == '0);
    assign ready      = (state == conv_pkg::IDLE) && (hand_state == conv_pkg::HAND_FREE);
    assign ifm_rd_en   = (state == conv_pkg::READ);
    assign ifm_rd_addr = pix_cnt;

    always_comb
    begin
        if (load_cnt < conv_pkg::KERNEL_TAPS)
            coef_rd_addr = conv_pkg::COEF_ADDR_W'(filt_cnt * conv_pkg::KERNEL_TAPS + load_cnt);
        else
            coef_rd_addr = conv_pkg::COEF_ADDR_W'(conv_pkg::BIAS_BASE + filt_cnt);
    end

    ////////////////////////////////////////////////////////////
    // Filter pass sequencing
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state    <= conv_pkg::IDLE;
            filt_cnt <= '0;
            load_cnt <= '0;
            pix_cnt  <= '0;
        end
        else
        begin
            case (state)
                conv_pkg::IDLE:
                begin
                    filt_cnt <= '0;
                    load_cnt <= '0;
                    if (ready && start_from_previous)
                        state <= conv_pkg::LOAD_W;
                end
                conv_pkg::LOAD_W:
                begin
                    load_cnt <= load_cnt + 1'b1;
                    pix_cnt  <= '0;
                    if (load_done)
                        state <= conv_pkg::READ;
                end
                conv_pkg::READ:
                begin
                    pix_cnt <= pix_cnt + 1'b1;
                    if (read_done)
                        state <= conv_pkg::DRAIN;
                end
                default:
                begin
                    load_cnt <= '0;
                    if (drain_done && filt_cnt == conv_pkg::NUM_FILTERS - 1)
                        state <= conv_pkg::IDLE;
                    else if (drain_done)
                    begin
                        filt_cnt <= filt_cnt + 1'b1;
                        state    <= conv_pkg::LOAD_W;
                    end
                end
            endcase
        end
    end

    // Position of the pixel entering the line buffer
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            row_cnt <= '0;
            col_cnt <= '0;
        end
        else if (shift_en)
        begin
            col_cnt <= (col_cnt == conv_pkg::IFM_SIZE - 1) ? '0 : col_cnt + 1'b1;
            if (col_cnt == conv_pkg::IFM_SIZE - 1)
                row_cnt <= (row_cnt == conv_pkg::IFM_SIZE - 1) ? '0 : row_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            shift_en   <= 1'b0;
            w_shift_en <= 1'b0;
            bias_sel   <= 1'b0;
            win_valid  <= 1'b0;
            we_pipe    <= '0;
        end
        else
        begin
            shift_en   <= ifm_rd_en;                              // RAM read latency
            w_shift_en <= (state == conv_pkg::LOAD_W) && (load_cnt < conv_pkg::KERNEL_TAPS);
            bias_sel   <= (state == conv_pkg::LOAD_W) && load_done;
            win_valid  <= shift_en && (row_cnt >= conv_pkg::KERNEL_SIZE - 1)
                          && (col_cnt >= conv_pkg::KERNEL_SIZE - 1);
            we_pipe    <= {we_pipe[conv_pkg::MAC_LATENCY-2:0], win_valid};
        end
    end

    assign ofm_we     = we_pipe[conv_pkg::MAC_LATENCY-1];
    assign last_write = ofm_we && (ofm_wr_addr == conv_pkg::OFM_WORDS - 1);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            ofm_wr_addr <= '0;
        else if (last_write)
            ofm_wr_addr <= '0;
        else if (ofm_we)
            ofm_wr_addr <= ofm_wr_addr + 1'b1;
    end

    ////////////////////////////////////////////////////////////
    // Bank handoff to the next layer
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            hand_state    <= conv_pkg::HAND_FREE;
            start_to_next <= 1'b0;
            bank_sel      <= 1'b0;
        end
        else
        begin
            start_to_next <= 1'b0;
            if (hand_state == conv_pkg::HAND_FREE && last_write)
                hand_state <= conv_pkg::HAND_WAIT;
            else if (hand_state == conv_pkg::HAND_WAIT && end_from_next)
            begin
                start_to_next <= 1'b1;
                bank_sel      <= ~bank_sel;                       // Finished bank goes to reader
                hand_state    <= conv_pkg::HAND_FREE;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/conv_layer.sv
`timescale 1ns/10ps
`default_nettype none

module conv_layer
(
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             start_from_previous,
    output logic                             ready,
    input  logic                             in_we,
    input  logic [conv_pkg::IFM_ADDR_W-1:0]  in_addr,
    input  conv_pkg::pixel_t                 in_data,
    input  logic                             coef_we,
    input  logic [conv_pkg::COEF_ADDR_W-1:0] coef_addr,
    input  conv_pkg::pixel_t                 coef_data,
    input  logic                             end_from_next,
    output logic                             start_to_next,
    input  logic [conv_pkg::OFM_ADDR_W-1:0]  ofm_rd_addr,
    output conv_pkg::acc_t                   ofm_rd_data
);

    logic                                         ifm_rd_en;
    logic [conv_pkg::IFM_ADDR_W-1:0]              ifm_rd_addr;
    conv_pkg::pixel_t                             ifm_rd_data;
    logic [conv_pkg::COEF_ADDR_W-1:0]             coef_rd_addr;
    logic                                         w_shift_en;
    logic                                         bias_sel;
    logic                                         shift_en;
    logic                                         win_valid;
    logic                                         ofm_we;
    logic [conv_pkg::OFM_ADDR_W-1:0]              ofm_wr_addr;
    logic                                         bank_sel;
    conv_pkg::pixel_t [conv_pkg::KERNEL_TAPS-1:0] window;
    conv_pkg::pixel_t [conv_pkg::KERNEL_TAPS-1:0] weights;
    conv_pkg::pixel_t                             bias;
    conv_pkg::acc_t                               mac_result;

    conv_ctrl u_conv_ctrl
    (
        .clk                 (clk),
        .reset               (reset),
        .start_from_previous (start_from_previous),
        .end_from_next       (end_from_next),
        .ready               (ready),
        .start_to_next       (start_to_next),
        .ifm_rd_en           (ifm_rd_en),
        .ifm_rd_addr         (ifm_rd_addr),
        .coef_rd_addr        (coef_rd_addr),
        .w_shift_en          (w_shift_en),
        .bias_sel            (bias_sel),
        .shift_en            (shift_en),
        .win_valid           (win_valid),
        .ofm_we              (ofm_we),
        .ofm_wr_addr         (ofm_wr_addr),
        .bank_sel            (bank_sel)
    );

    ifm_ram u_ifm_ram
    (
        .clk     (clk),
        .we      (in_we),
        .wr_addr (in_addr),
        .wr_data (in_data),
        .rd_en   (ifm_rd_en),
        .rd_addr (ifm_rd_addr),
        .rd_data (ifm_rd_data)
    );

    line_buffer u_line_buffer
    (
        .clk      (clk),
        .reset    (reset),
        .shift_en (shift_en),
        .pixel_in (ifm_rd_data),
        .window   (window)
    );

    kernel_store u_kernel_store
    (
        .clk        (clk),
        .we         (coef_we),
        .wr_addr    (coef_addr),
        .wr_data    (coef_data),
        .rd_addr    (coef_rd_addr),
        .w_shift_en (w_shift_en),
        .bias_sel   (bias_sel),
        .weights    (weights),
        .bias       (bias)
    );

    conv_mac u_conv_mac
    (
        .clk     (clk),
        .reset   (reset),
        .window  (window),
        .weights (weights),
        .bias    (bias),
        .result  (mac_result)
    );

    ofm_pingpong u_ofm_pingpong
    (
        .clk      (clk),
        .we       (ofm_we),
        .wr_addr  (ofm_wr_addr),
        .wr_data  (mac_result),
        .bank_sel (bank_sel),
        .rd_addr  (ofm_rd_addr),
        .rd_data  (ofm_rd_data)
    );

endmodule

`default_nettype wire

//--- dv/conv_layer_chk.sv
`timescale 1ns/10ps
`default_nettype none

module conv_layer_chk
(
    input logic                     clk,
    input logic                     reset,
    input logic                     ready,
    input logic                     start_to_next,
    input logic                     ofm_we,
    input logic                     bank_sel,
    input conv_pkg::handoff_state_e hand_state
);

    int fail_cnt = 0;   // Read by the testbench at the end

    ////////////////////////////////////////////////////////////
    // Handoff protocol
    pulse_one_cycle: assert property (@(posedge clk) disable iff (reset)
        start_to_next |=> !start_to_next)
    else
    begin
        fail_cnt++;
        $error("start_to_next stayed high for more than one cycle");
    end

    ready_low_in_wait: assert property (@(posedge clk) disable iff (reset)
        (hand_state == conv_pkg::HAND_WAIT) |-> !ready)
    else
    begin
        fail_cnt++;
        $error("ready was high while the handoff was pending");
    end

    // Bank flips only on the handoff pulse
    bank_with_pulse: assert property (@(posedge clk) disable iff (reset)
        $changed(bank_sel) |-> start_to_next)
    else
    begin
        fail_cnt++;
        $error("bank_sel changed without start_to_next");
    end

    ////////////////////////////////////////////////////////////
    // Write pacing
    no_write_when_ready: assert property (@(posedge clk) disable iff (reset)
        $rose(ofm_we) |-> !ready)
    else
    begin
        fail_cnt++;
        $error("ofm_we rose while the layer was ready");
    end

endmodule

`default_nettype wire

//--- dv/conv_layer_tb.sv
`timescale 1ns/10ps
`default_nettype none

module conv_layer_tb;

    typedef enum logic [1:0] {PAT_RAMP, PAT_CHECKER, PAT_LFSR} pattern_e;

    typedef struct packed {
        pattern_e     pattern;
        logic [159:0] coefs;    // Byte k goes to coefficient address k
        logic [15:0]  hold;     // Cycles the consumer keeps end_from_next low
    } frame_row_t;

    localparam int NUM_ROWS     = 3;
    localparam int HAND_TIMEOUT = 600;

    // Leftmost byte is address 19, so the two biases come first
    localparam frame_row_t ROWS [NUM_ROWS] = '{
        '{PAT_RAMP,    160'h0AF60102_03FF0001_02FEFD01_00020101_FF010203, 16'd0},
        '{PAT_CHECKER, 160'h7F8010F0_08F804FC_02FE01FF_20E011EF_05FB03FD, 16'd200},
        '{PAT_LFSR,    160'h817F817F_817F817F_817F7F7F_7F7F7F7F_7F7F8181, 16'd260}
    };

    logic                             clk;
    logic                             reset;
    logic                             start_from_previous;
    logic                             ready;
    logic                             in_we;
    logic [conv_pkg::IFM_ADDR_W-1:0]  in_addr;
    conv_pkg::pixel_t                 in_data;
    logic                             coef_we;
    logic [conv_pkg::COEF_ADDR_W-1:0] coef_addr;
    conv_pkg::pixel_t                 coef_data;
    logic                             end_from_next;
    logic                             start_to_next;
    logic [conv_pkg::OFM_ADDR_W-1:0]  ofm_rd_addr;
    conv_pkg::acc_t                   ofm_rd_data;

    conv_pkg::pixel_t pix [conv_pkg::IFM_WORDS];
    logic [159:0]     coefs;
    int               errors = 0;
    int               assert_errors;
    bit               timed_out = 1'b0;

    conv_layer u_conv_layer (.*);

    bind conv_ctrl conv_layer_chk u_conv_layer_chk (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Reference model

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic conv_pkg::pixel_t coef_at(input int addr);
        return conv_pkg::pixel_t'(coefs[8*addr +: 8]);
    endfunction

    function automatic void make_pixels(input pattern_e kind);
        logic [31:0] lfsr;
        logic [7:0]  b;
        lfsr = 32'h8b7812a1;
        for (int p = 0; p < conv_pkg::IFM_WORDS; p++)
        begin
            case (kind)
                PAT_RAMP:    pix[p] = conv_pkg::pixel_t'(p * 3 - 96);
                PAT_CHECKER: pix[p] = ((p / 8 + p % 8) % 2 == 1) ? 8'sd100 : -8'sd100;
                default:
                begin
                    for (int k = 0; k < 8; k++)
                    begin
                        lfsr = lfsr_next(lfsr);    // One step per bit
                        b[k] = lfsr[0];
                    end
                    pix[p] = conv_pkg::pixel_t'(b);
                end
            endcase
        end
    endfunction

    // Output (f, y, x) sits at f*36 + y*6 + x
    function automatic conv_pkg::acc_t expected_result(input int addr);
        int             f;
        int             y;
        int             x;
        conv_pkg::acc_t acc;
        f   = addr / 36;
        y   = (addr % 36) / 6;
        x   = addr % 6;
        acc = conv_pkg::acc_t'(coef_at(18 + f));
        for (int i = 0; i < 3; i++)
            for (int j = 0; j < 3; j++)
                acc += coef_at(f*9 + i*3 + j) * pix[(y+i)*8 + x + j];
        return acc;
    endfunction

    task automatic check_acc(input conv_pkg::acc_t got, input conv_pkg::acc_t exp,
                             input string what);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t %s: got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("ERR %0t %s: got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic wait_handoff(output bit seen);
        seen = 1'b0;
        for (int n = 0; n < HAND_TIMEOUT && !seen; n++)
        begin
            @(negedge clk);
            seen = start_to_next;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One frame of load, start, handoff and readback
    task automatic run_frame(input frame_row_t row);
        bit seen;
        make_pixels(row.pattern);
        coefs = row.coefs;
        for (int k = 0; k < conv_pkg::IFM_WORDS; k++)
        begin
            @(posedge clk);
            in_we     <= 1'b1;
            in_addr   <= conv_pkg::IFM_ADDR_W'(k);
            in_data   <= pix[k];
            coef_we   <= (k < 20);
            coef_addr <= conv_pkg::COEF_ADDR_W'(k);
            coef_data <= coef_at(k % 20);
        end
        @(posedge clk);
        in_we               <= 1'b0;
        coef_we             <= 1'b0;
        start_from_previous <= 1'b1;
        end_from_next       <= (row.hold == 0);
        @(posedge clk);
        start_from_previous <= 1'b0;
        repeat (60) @(posedge clk);
        start_from_previous <= 1'b1;    // Must be ignored mid frame
        @(posedge clk);
        start_from_previous <= 1'b0;
        @(negedge clk);
        check_bit(ready, 1'b0, "ready while busy");
        for (int n = 0; n < row.hold; n++)
        begin
            @(negedge clk);
            check_bit(start_to_next, 1'b0, "start_to_next while consumer busy");
            check_bit(ready, 1'b0, "ready while consumer busy");
        end
        @(posedge clk);
        end_from_next <= 1'b1;
        wait_handoff(seen);
        if (!seen)
        begin
            timed_out = 1'b1;
            $display("Timeout: start_to_next never came after the frame");
        end
        else
        begin
            @(negedge clk);
            check_bit(start_to_next, 1'b0, "extra start_to_next");
            check_bit(ready, 1'b1, "ready after handoff");
            for (int a = 0; a < conv_pkg::OFM_WORDS; a++)
            begin
                @(posedge clk);
                ofm_rd_addr <= conv_pkg::OFM_ADDR_W'(a);
                @(posedge clk);
                @(negedge clk);
                check_acc(ofm_rd_data, expected_result(a), $sformatf("result %0d", a));
            end
        end
    endtask

    initial
    begin
        reset               = 1'b1;
        start_from_previous = 1'b0;
        in_we               = 1'b0;
        in_addr             = '0;
        in_data             = '0;
        coef_we             = 1'b0;
        coef_addr           = '0;
        coef_data           = '0;
        end_from_next       = 1'b0;
        ofm_rd_addr         = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_bit(ready, 1'b1, "ready after reset");
        check_bit(start_to_next, 1'b0, "start_to_next after reset");
        for (int r = 0; r < NUM_ROWS && !timed_out; r++)
            run_frame(ROWS[r]);
        assert_errors = u_conv_layer.u_conv_ctrl.u_conv_layer_chk.fail_cnt;
        $display("Errors: %0d value, %0d assertion, %0d timeout",
                 errors, assert_errors, timed_out);
        if (errors == 0 && assert_errors == 0 && !timed_out)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hdl/conv_pkg.sv
hdl/ifm_ram.sv
hdl/line_buffer.sv
hdl/kernel_store.sv
hdl/conv_mac.sv
hdl/ofm_pingpong.sv
hdl/conv_ctrl.sv
hdl/conv_layer.sv
dv/conv_layer_chk.sv
dv/conv_layer_tb.sv
